/* design/fmb_consts.svh */
// Shared constants for the memory tester: bus widths, burst shape and test region
`ifndef FMB_CONSTS_SVH
`define FMB_CONSTS_SVH

// AXI4 bus geometry
`define FMB_DATA_W          64
`define FMB_STRB_W          8
`define FMB_ADDR_W          33
`define FMB_ID_W            6

// One burst is 16 beats of 8 bytes
`define FMB_BURST_LEN       16
`define FMB_BURST_BYTES     128
// Region under test starts at address 0
`define FMB_TEST_BURSTS     8
`define FMB_PATTERN_SEED    64'hA5C3_5A3C_0F1E_2D4B
// Config reset hold after reset release
`define FMB_CFG_RST_CYCLES  16
`endif

/* design/fmb_pkg.sv */
// Common types and the data pattern used by the memory tester
`default_nettype none
`include "fmb_consts.svh"

package fmb_pkg;

	// DDR controller bring-up steps
	typedef enum logic [1:0] {
		CFG_HOLD,
		CFG_START,
		CFG_WAIT_DONE,
		CFG_READY
	} cfg_state_e;

	// Test walk over the region
	typedef enum logic [2:0] {
		TST_IDLE,
		TST_WR_ISSUE,
		TST_WR_WAIT,
		TST_RD_ISSUE,
		TST_RD_WAIT,
		TST_PASS,
		TST_FAIL
	} test_state_e;

	// AXI BRESP / RRESP codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// Expected beat data, byte address folded into a fixed seed
	function automatic logic [`FMB_DATA_W-1:0] fmb_pattern(input logic [`FMB_ADDR_W-1:0] addr);
		return {{(`FMB_DATA_W-`FMB_ADDR_W){1'b0}}, addr} ^ `FMB_PATTERN_SEED;
	endfunction

endpackage

`default_nettype wire

/* design/mem_cmd_if.sv */
// Command handshake between the test controller and one AXI burst engine
`timescale 1ns/1ns
`default_nettype none
`include "fmb_consts.svh"

interface mem_cmd_if;
	// Controller side, one-cycle start with the burst base address
	logic                   start;
	logic [`FMB_ADDR_W-1:0] base_addr;
	// Engine side, error only meaningful with done
	logic                   done;
	logic                   error;

	modport ctrl (
		output start,
		output base_addr,
		input  done,
		input  error
	);

	// Engine samples base_addr in the start cycle
	modport engine (
		input  start,
		input  base_addr,
		output done,
		output error
	);
endinterface

`default_nettype wire

/* design/ddr_reset_sequencer.sv */
// Reset synchronizer and DDR controller bring-up: config reset, calibration start, AXI reset
`timescale 1ns/1ns
`default_nettype none
`include "fmb_consts.svh"

module ddr_reset_sequencer (
	input  wire  iSCLK,
	input  wire  qLocked,
	input  wire  i_ddr_cfg_done,
	output logic o_ddr_cfg_reset,
	output logic o_ddr_cfg_start,
	output logic o_ddr_axi_rstn,
	output logic o_cfg_done,
	output logic o_srst_n
);
	import fmb_pkg::*;

	localparam int HOLD_W = $clog2(`FMB_CFG_RST_CYCLES);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`FMB_CFG_RST_CYCLES - 1);

	logic [1:0]        sync_q;
	cfg_state_e        state;
	logic [HOLD_W-1:0] hold_cnt;

	// ------------------------------------------------------------------
	// Two-flop release of the lock reset
	// ------------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
			sync_q <= 2'b00;
		else
			sync_q <= {sync_q[0], 1'b1};
	end

	assign o_srst_n = sync_q[1];

	// ------------------------------------------------------------------
	// Bring-up FSM
	// ------------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state    <= CFG_HOLD;
			hold_cnt <= '0;
		end
		else if (!o_srst_n)
		begin
			state    <= CFG_HOLD;
			hold_cnt <= '0;
		end
		else
		begin
			case (state)
				// Config reset held for a fixed count
				CFG_HOLD:
					if (hold_cnt == HOLD_LAST)
						state <= CFG_START;
					else
						hold_cnt <= hold_cnt + 1'b1;
				CFG_START:
					state <= CFG_WAIT_DONE;
				// Calibration running
				CFG_WAIT_DONE:
					if (i_ddr_cfg_done)
						state <= CFG_READY;
				default:
					state <= CFG_READY;
			endcase
		end
	end

	assign o_ddr_cfg_reset = (state == CFG_HOLD);
	assign o_ddr_cfg_start = (state == CFG_START) || (state == CFG_WAIT_DONE);
	// AXI side leaves reset with the done flag
	assign o_ddr_axi_rstn  = (state == CFG_READY);
	assign o_cfg_done      = (state == CFG_READY);

	a_no_reset_with_start: assert property (@(posedge iSCLK) disable iff (!qLocked)
		!(o_ddr_cfg_start && o_ddr_cfg_reset));

endmodule

`default_nettype wire

/* design/mem_test_ctrl.sv */
// Test controller: write phase then read-back phase over the region, burst by burst
`timescale 1ns/1ns
`default_nettype none
`include "fmb_consts.svh"

module mem_test_ctrl (
	input  wire         iSCLK,
	input  wire         qLocked,
	input  wire         i_srst_n,
	input  wire         i_cfg_done,
	mem_cmd_if.ctrl     wr_cmd,
	mem_cmd_if.ctrl     rd_cmd,
	output logic        o_test_run,
	output logic        o_test_fail,
	output logic        o_test_done
);
	import fmb_pkg::*;

	localparam int CNT_W = $clog2(`FMB_TEST_BURSTS);
	localparam int BB_W  = $clog2(`FMB_BURST_BYTES);
	localparam logic [CNT_W-1:0] LAST_BURST = CNT_W'(`FMB_TEST_BURSTS - 1);

	test_state_e            state;
	logic [CNT_W-1:0]       burst_cnt;
	logic [`FMB_ADDR_W-1:0] burst_addr;
	logic                   wr_busy;
	logic                   rd_busy;

	// Burst base, counter times burst size
	assign burst_addr = {{(`FMB_ADDR_W-CNT_W-BB_W){1'b0}}, burst_cnt, {BB_W{1'b0}}};

	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state     <= TST_IDLE;
			burst_cnt <= '0;
		end
		else if (!i_srst_n)
			state <= TST_IDLE;
		else
		begin
			case (state)
				TST_IDLE:
					if (i_cfg_done)
					begin
						state     <= TST_WR_ISSUE;
						burst_cnt <= '0;
					end
				TST_WR_ISSUE:
					state <= TST_WR_WAIT;
				TST_WR_WAIT:
					if (wr_cmd.done)
					begin
						// Any write error stops the run
						if (wr_cmd.error)
							state <= TST_FAIL;
						else if (burst_cnt == LAST_BURST)
						begin
							state     <= TST_RD_ISSUE;
							burst_cnt <= '0;
						end
						else
						begin
							state     <= TST_WR_ISSUE;
							burst_cnt <= burst_cnt + 1'b1;
						end
					end
				TST_RD_ISSUE:
					state <= TST_RD_WAIT;
				TST_RD_WAIT:
					if (rd_cmd.done)
					begin
						if (rd_cmd.error)
							state <= TST_FAIL;
						else if (burst_cnt == LAST_BURST)
							state <= TST_PASS;
						else
						begin
							state     <= TST_RD_ISSUE;
							burst_cnt <= burst_cnt + 1'b1;
						end
					end
				// Pass and fail hold until the next reset
				TST_PASS:
					state <= TST_PASS;
				TST_FAIL:
					state <= TST_FAIL;
				default:
					state <= TST_IDLE;
			endcase
		end
	end

	assign wr_cmd.start     = (state == TST_WR_ISSUE);
	assign wr_cmd.base_addr = burst_addr;
	assign rd_cmd.start     = (state == TST_RD_ISSUE);
	assign rd_cmd.base_addr = burst_addr;

	// Status for the LEDs
	assign o_test_run  = (state != TST_IDLE) && (state != TST_PASS) && (state != TST_FAIL);
	assign o_test_fail = (state == TST_FAIL);
	assign o_test_done = (state == TST_PASS) || (state == TST_FAIL);

	// Engine busy from start until its done pulse
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			wr_busy <= 1'b0;
			rd_busy <= 1'b0;
		end
		else
		begin
			wr_busy <= wr_cmd.start | (wr_busy & ~wr_cmd.done);
			rd_busy <= rd_cmd.start | (rd_busy & ~rd_cmd.done);
		end
	end

	a_wr_one_cmd: assert property (@(posedge iSCLK) disable iff (!i_srst_n)
		wr_cmd.start |-> !wr_busy);
	a_rd_one_cmd: assert property (@(posedge iSCLK) disable iff (!i_srst_n)
		rd_cmd.start |-> !rd_busy);

endmodule

`default_nettype wire

/* design/axi_burst_writer.sv */
// AXI4 write master: one INCR burst of pattern data per command, then the response check
`timescale 1ns/1ns
`default_nettype none
`include "fmb_consts.svh"

module axi_burst_writer (
	input  wire                     iSCLK,
	input  wire                     qLocked,
	input  wire                     i_srst_n,
	mem_cmd_if.engine               cmd,
	output logic [`FMB_ID_W-1:0]    o_awid,
	output logic [`FMB_ADDR_W-1:0]  o_awaddr,
	output logic [7:0]              o_awlen,
	output logic [2:0]              o_awsize,
	output logic [1:0]              o_awburst,
	output logic                    o_awvalid,
	input  wire                     i_awready,
	output logic [`FMB_DATA_W-1:0]  o_wdata,
	output logic [`FMB_STRB_W-1:0]  o_wstrb,
	output logic                    o_wlast,
	output logic                    o_wvalid,
	input  wire                     i_wready,
	input  wire  [1:0]              i_bresp,
	input  wire                     i_bvalid,
	output logic                    o_bready
);
	import fmb_pkg::*;

	localparam int BEAT_W = $clog2(`FMB_BURST_LEN);
	localparam int OFF_W  = $clog2(`FMB_STRB_W);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`FMB_BURST_LEN - 1);

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_DATA,
		W_RESP
	} wr_state_e;

	wr_state_e              state;
	logic [`FMB_ADDR_W-1:0] base_q;
	logic [BEAT_W-1:0]      beat;
	logic [`FMB_ADDR_W-1:0] beat_addr;
	logic                   w_hs;
	logic [BEAT_W-1:0]      w_hs_cnt;

	// Byte address of the current beat
	assign beat_addr = base_q + {{(`FMB_ADDR_W-BEAT_W-OFF_W){1'b0}}, beat, {OFF_W{1'b0}}};

	// Fixed burst shape, full strobes, ID 0
	assign o_awid    = '0;
	assign o_awaddr  = base_q;
	assign o_awlen   = 8'(`FMB_BURST_LEN - 1);
	assign o_awsize  = 3'(OFF_W);
	assign o_awburst = 2'b01;
	assign o_awvalid = (state == W_ADDR);
	assign o_wdata   = fmb_pattern(beat_addr);
	assign o_wstrb   = '1;
	assign o_wlast   = (beat == LAST_BEAT);
	assign o_wvalid  = (state == W_DATA);
	assign o_bready  = (state == W_RESP);
	assign w_hs      = o_wvalid && i_wready;

	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state     <= W_IDLE;
			beat      <= '0;
			cmd.done  <= 1'b0;
			cmd.error <= 1'b0;
		end
		else if (!i_srst_n)
		begin
			state    <= W_IDLE;
			cmd.done <= 1'b0;
		end
		else
		begin
			cmd.done <= 1'b0;
			case (state)
				W_IDLE:
					if (cmd.start)
					begin
						state <= W_ADDR;
						beat  <= '0;
					end
				W_ADDR:
					if (i_awready)
						state <= W_DATA;
				// Data only after the address handshake
				W_DATA:
					if (i_wready)
					begin
						if (o_wlast)
							state <= W_RESP;
						else
							beat <= beat + 1'b1;
					end
				W_RESP:
					if (i_bvalid)
					begin
						state     <= W_IDLE;
						cmd.done  <= 1'b1;
						cmd.error <= (i_bresp != RESP_OKAY);
					end
				default:
					state <= W_IDLE;
			endcase
		end
	end

	// Burst base taken in the start cycle
	always_ff @(posedge iSCLK)
	begin
		if ((state == W_IDLE) && cmd.start)
			base_q <= cmd.base_addr;
	end

	// Running beat count over all bursts, last must land on every 16th
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
			w_hs_cnt <= '0;
		else if (w_hs)
			w_hs_cnt <= w_hs_cnt + 1'b1;
	end

	a_wlast_final: assert property (@(posedge iSCLK) disable iff (!i_srst_n)
		w_hs |-> (o_wlast == (w_hs_cnt == LAST_BEAT)));

endmodule

`default_nettype wire

/* design/axi_burst_reader.sv */
// AXI4 read master: one burst per command, every beat compared against the pattern
`timescale 1ns/1ns
`default_nettype none
`include "fmb_consts.svh"

module axi_burst_reader (
	input  wire                     iSCLK,
	input  wire                     qLocked,
	input  wire                     i_srst_n,
	mem_cmd_if.engine               cmd,
	output logic [`FMB_ID_W-1:0]    o_arid,
	output logic [`FMB_ADDR_W-1:0]  o_araddr,
	output logic [7:0]              o_arlen,
	output logic [2:0]              o_arsize,
	output logic [1:0]              o_arburst,
	output logic                    o_arvalid,
	input  wire                     i_arready,
	input  wire  [`FMB_DATA_W-1:0]  i_rdata,
	input  wire  [1:0]              i_rresp,
	input  wire                     i_rlast,
	input  wire                     i_rvalid,
	output logic                    o_rready
);
	import fmb_pkg::*;

	localparam int BEAT_W = $clog2(`FMB_BURST_LEN);
	localparam int OFF_W  = $clog2(`FMB_STRB_W);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`FMB_BURST_LEN - 1);

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA
	} rd_state_e;

	rd_state_e              state;
	logic [`FMB_ADDR_W-1:0] base_q;
	logic [BEAT_W-1:0]      beat;
	logic [`FMB_ADDR_W-1:0] beat_addr;
	logic                   final_beat;
	logic                   beat_bad;
	logic                   err_acc;

	assign beat_addr  = base_q + {{(`FMB_ADDR_W-BEAT_W-OFF_W){1'b0}}, beat, {OFF_W{1'b0}}};
	assign final_beat = (beat == LAST_BEAT);
	// Data, response and last position all checked per beat
	assign beat_bad   = (i_rdata != fmb_pattern(beat_addr)) || (i_rresp != RESP_OKAY) ||
		(i_rlast != final_beat);

	assign o_arid    = '0;
	assign o_araddr  = base_q;
	assign o_arlen   = 8'(`FMB_BURST_LEN - 1);
	assign o_arsize  = 3'(OFF_W);
	assign o_arburst = 2'b01;
	assign o_arvalid = (state == R_ADDR);
	// Always ready through the data phase
	assign o_rready  = (state == R_DATA);

	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state     <= R_IDLE;
			beat      <= '0;
			err_acc   <= 1'b0;
			cmd.done  <= 1'b0;
			cmd.error <= 1'b0;
		end
		else if (!i_srst_n)
		begin
			state    <= R_IDLE;
			cmd.done <= 1'b0;
		end
		else
		begin
			cmd.done <= 1'b0;
			case (state)
				R_IDLE:
					if (cmd.start)
					begin
						state   <= R_ADDR;
						beat    <= '0;
						err_acc <= 1'b0;
					end
				R_ADDR:
					if (i_arready)
						state <= R_DATA;
				R_DATA:
					if (i_rvalid)
					begin
						err_acc <= err_acc | beat_bad;
						// Early rlast also ends the burst, already flagged
						if (i_rlast || final_beat)
						begin
							state     <= R_IDLE;
							cmd.done  <= 1'b1;
							cmd.error <= err_acc | beat_bad;
						end
						else
							beat <= beat + 1'b1;
					end
				default:
					state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if ((state == R_IDLE) && cmd.start)
			base_q <= cmd.base_addr;
	end

	// Address request held steady until accepted
	a_arvalid_hold: assert property (@(posedge iSCLK) disable iff (!i_srst_n)
		(o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr)));

endmodule

`default_nettype wire

/* design/fmb_tester_top.sv */
// Memory tester top: lock reset, DDR bring-up, write/read-back engines and status LEDs
`timescale 1ns/1ns
`default_nettype none
`include "fmb_consts.svh"

module fmb_tester_top (
	input  wire                     iSCLK,
	input  wire                     i_pb_sw,
	input  wire                     i_pll_bl1_locked,
	input  wire                     i_pll_tl2_locked,
	// DDR controller config
	input  wire                     i_ddr_cfg_done,
	output logic                    o_ddr_cfg_reset,
	output logic                    o_ddr_cfg_start,
	output logic                    o_ddr_axi_rstn,
	// AXI4 write channels
	output logic [`FMB_ID_W-1:0]    o_awid,
	output logic [`FMB_ADDR_W-1:0]  o_awaddr,
	output logic [7:0]              o_awlen,
	output logic [2:0]              o_awsize,
	output logic [1:0]              o_awburst,
	output logic                    o_awvalid,
	input  wire                     i_awready,
	output logic [`FMB_DATA_W-1:0]  o_wdata,
	output logic [`FMB_STRB_W-1:0]  o_wstrb,
	output logic                    o_wlast,
	output logic                    o_wvalid,
	input  wire                     i_wready,
	input  wire  [1:0]              i_bresp,
	input  wire                     i_bvalid,
	output logic                    o_bready,
	// AXI4 read channels
	output logic [`FMB_ID_W-1:0]    o_arid,
	output logic [`FMB_ADDR_W-1:0]  o_araddr,
	output logic [7:0]              o_arlen,
	output logic [2:0]              o_arsize,
	output logic [1:0]              o_arburst,
	output logic                    o_arvalid,
	input  wire                     i_arready,
	input  wire  [`FMB_DATA_W-1:0]  i_rdata,
	input  wire  [1:0]              i_rresp,
	input  wire                     i_rlast,
	input  wire                     i_rvalid,
	output logic                    o_rready,
	// cfg start, cfg done, run, fail, done
	output logic [4:0]              o_led
);
	logic qLocked;
	logic srst_n;
	logic cfg_done;
	logic test_run;
	logic test_fail;
	logic test_done;

	// Any switch or PLL drop resets the whole tester
	assign qLocked = &{i_pb_sw, i_pll_bl1_locked, i_pll_tl2_locked};

	mem_cmd_if wr_cmd ();
	mem_cmd_if rd_cmd ();

	// ------------------------------------------------------------------
	// Bring-up, test walk, bus engines
	// ------------------------------------------------------------------
	ddr_reset_sequencer u_ddr_reset_sequencer (
		.*,
		.o_cfg_done (cfg_done),
		.o_srst_n   (srst_n)
	);

	mem_test_ctrl u_mem_test_ctrl (
		.iSCLK       (iSCLK),
		.qLocked     (qLocked),
		.i_srst_n    (srst_n),
		.i_cfg_done  (cfg_done),
		.wr_cmd      (wr_cmd),
		.rd_cmd      (rd_cmd),
		.o_test_run  (test_run),
		.o_test_fail (test_fail),
		.o_test_done (test_done)
	);

	axi_burst_writer u_axi_burst_writer (
		.*,
		.i_srst_n (srst_n),
		.cmd      (wr_cmd)
	);

	axi_burst_reader u_axi_burst_reader (
		.*,
		.i_srst_n (srst_n),
		.cmd      (rd_cmd)
	);

	assign o_led = {test_done, test_fail, test_run, cfg_done, o_ddr_cfg_start};

endmodule

`default_nettype wire

/* dv/tb_fmb_tester.sv */
// Directed testbench for the memory tester, with a behavioral AXI4 memory and fault injection
`timescale 1ns/1ns
`default_nettype none
`include "fmb_consts.svh"

module tb_fmb_tester;

	localparam int RESET_CYCLES    = 4;
	localparam int MEM_WORDS       = `FMB_TEST_BURSTS * `FMB_BURST_BYTES / 8;
	// Two sync flops plus the config reset hold
	localparam int START_CYCLES    = 2 + `FMB_CFG_RST_CYCLES;
	localparam int TEST_CYCLES     = 2 * `FMB_TEST_BURSTS * (`FMB_BURST_LEN + 8) * 4;
	localparam int NUM_TESTS       = 5;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES;
	localparam logic [63:0] FLIP_MASK = 64'h0000_0000_0002_0000;
	// LED bits from done down to cfg start
	localparam logic [4:0] LED_PASS = 5'b10010;
	localparam logic [4:0] LED_FAIL = 5'b11010;

	logic iSCLK;
	logic i_pb_sw, i_pll_bl1_locked, i_pll_tl2_locked;
	logic i_ddr_cfg_done;
	logic o_ddr_cfg_reset, o_ddr_cfg_start, o_ddr_axi_rstn;
	logic [`FMB_ID_W-1:0]   o_awid, o_arid;
	logic [`FMB_ADDR_W-1:0] o_awaddr, o_araddr;
	logic [7:0]             o_awlen, o_arlen;
	logic [2:0]             o_awsize, o_arsize;
	logic [1:0]             o_awburst, o_arburst;
	logic                   o_awvalid, o_wlast, o_wvalid, o_bready, o_arvalid, o_rready;
	logic [`FMB_DATA_W-1:0] o_wdata;
	logic [`FMB_STRB_W-1:0] o_wstrb;
	logic [4:0]             o_led;

	// Slave side of the bus driven by the memory model
	logic                   i_awready = 1'b0;
	logic                   i_wready  = 1'b0;
	logic                   i_arready = 1'b0;
	logic                   i_bvalid  = 1'b0;
	logic [1:0]             i_bresp   = 2'b00;
	logic                   i_rvalid  = 1'b0;
	logic                   i_rlast   = 1'b0;
	logic [1:0]             i_rresp   = 2'b00;
	logic [`FMB_DATA_W-1:0] i_rdata   = '0;

	// Memory model state
	logic [63:0] mem [0:MEM_WORDS-1];
	logic [6:0]  wr_ptr, rd_ptr;
	logic [8:0]  rd_left;
	logic [7:0]  aw_count, ar_count;
	logic        corrupt_used, slverr_used;
	logic        stall_en, corrupt_en, slverr_en;
	logic [15:0] lfsr = 16'd16768;
	logic        rgo;
	int          fill_idx;

	fmb_tester_top i_fmb_tester_top (.*);

	// ------------------------------------------------------------------
	// Clock and watchdog
	// ------------------------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #4 iSCLK = ~iSCLK;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge iSCLK);
		$display("TEST FAIL");
		$fatal(1, "Watchdog expired before all tests finished");
	end

	// Expected word at a word index is the seed with the byte address XOR-ed in
	function automatic logic [63:0] expected_word(input int idx);
		return `FMB_PATTERN_SEED ^ (64'(idx) << 3);
	endfunction

	// 16-bit Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "Value mismatch");
		end
	endtask

	// ------------------------------------------------------------------
	// Behavioral AXI4 memory
	// ------------------------------------------------------------------
	always @(posedge iSCLK)
	begin
		// One LFSR bit per ready and one for the read beat gate
		if (stall_en)
		begin
			lfsr = lfsr_step(lfsr);
			i_awready <= lfsr[0];
			lfsr = lfsr_step(lfsr);
			i_wready <= lfsr[0];
			lfsr = lfsr_step(lfsr);
			i_arready <= lfsr[0];
			lfsr = lfsr_step(lfsr);
			rgo = lfsr[0];
		end
		else
		begin
			i_awready <= 1'b1;
			i_wready  <= 1'b1;
			i_arready <= 1'b1;
			rgo = 1'b1;
		end

		if (!i_pb_sw)
		begin
			aw_count     <= '0;
			ar_count     <= '0;
			i_bvalid     <= 1'b0;
			i_rvalid     <= 1'b0;
			i_rlast      <= 1'b0;
			rd_left      <= '0;
			corrupt_used <= 1'b0;
			slverr_used  <= 1'b0;
			// Inverted pattern makes unwritten locations show up
			for (fill_idx = 0; fill_idx < MEM_WORDS; fill_idx++)
				mem[fill_idx] <= ~expected_word(fill_idx);
		end
		else
		begin
			// Write address
			if (o_awvalid && i_awready)
			begin
				check_eq("o_awid", 64'(o_awid), 64'd0);
				check_eq("o_awlen", 64'(o_awlen), 64'(`FMB_BURST_LEN - 1));
				// 8-byte beats in INCR bursts
				check_eq("o_awsize", 64'(o_awsize), 64'd3);
				check_eq("o_awburst", 64'(o_awburst), 64'd1);
				wr_ptr   <= o_awaddr[9:3];
				aw_count <= aw_count + 8'd1;
			end
			// Write data with the response after the last beat
			if (o_wvalid && i_wready)
			begin
				check_eq("o_wstrb", 64'(o_wstrb), 64'hFF);
				mem[wr_ptr] <= o_wdata;
				wr_ptr      <= wr_ptr + 7'd1;
				if (o_wlast)
				begin
					i_bvalid <= 1'b1;
					if (slverr_en && !slverr_used)
					begin
						i_bresp     <= 2'b10;
						slverr_used <= 1'b1;
					end
					else
						i_bresp <= 2'b00;
				end
			end
			else if (i_bvalid && o_bready)
				i_bvalid <= 1'b0;

			// Read address
			if (o_arvalid && i_arready)
			begin
				check_eq("o_arid", 64'(o_arid), 64'd0);
				check_eq("o_arlen", 64'(o_arlen), 64'(`FMB_BURST_LEN - 1));
				check_eq("o_arsize", 64'(o_arsize), 64'd3);
				check_eq("o_arburst", 64'(o_arburst), 64'd1);
				rd_ptr   <= o_araddr[9:3];
				rd_left  <= 9'(o_arlen) + 9'd1;
				ar_count <= ar_count + 8'd1;
			end
			// Read data as one beat then a gap
			if (i_rvalid && o_rready)
				i_rvalid <= 1'b0;
			else if (!i_rvalid && (rd_left != 9'd0) && rgo)
			begin
				i_rvalid <= 1'b1;
				i_rresp  <= 2'b00;
				i_rlast  <= (rd_left == 9'd1);
				rd_ptr   <= rd_ptr + 7'd1;
				rd_left  <= rd_left - 9'd1;
				if (corrupt_en && !corrupt_used)
				begin
					i_rdata      <= mem[rd_ptr] ^ FLIP_MASK;
					corrupt_used <= 1'b1;
				end
				else
					i_rdata <= mem[rd_ptr];
			end
		end
	end

	// ------------------------------------------------------------------
	// Sequencing helpers
	// ------------------------------------------------------------------
	task automatic hold_locks_low(input logic stall, input logic corrupt, input logic slverr);
		@(posedge iSCLK);
		i_pb_sw          <= 1'b0;
		i_pll_bl1_locked <= 1'b0;
		i_pll_tl2_locked <= 1'b0;
		i_ddr_cfg_done   <= 1'b0;
		stall_en         <= stall;
		corrupt_en       <= corrupt;
		slverr_en        <= slverr;
		repeat (RESET_CYCLES) @(posedge iSCLK);
	endtask

	// Called on a rising edge
	task automatic release_locks(input logic cfg_done);
		i_pb_sw          <= 1'b1;
		i_pll_bl1_locked <= 1'b1;
		i_pll_tl2_locked <= 1'b1;
		i_ddr_cfg_done   <= cfg_done;
	endtask

	task automatic run_memory_test(input logic stall, input logic corrupt, input logic slverr);
		int cycles;
		cycles = 0;
		hold_locks_low(stall, corrupt, slverr);
		release_locks(1'b1);
		while ((o_led[4] !== 1'b1) && (cycles < TEST_CYCLES))
		begin
			@(negedge iSCLK);
			cycles++;
		end
		if (o_led[4] !== 1'b1)
		begin
			$display("TEST FAIL");
			$fatal(1, "Test done LED never came on");
		end
	endtask

	task automatic check_clean_result();
		int idx;
		check_eq("o_led", 64'(o_led), 64'(LED_PASS));
		for (idx = 0; idx < MEM_WORDS; idx++)
			check_eq($sformatf("mem[%0d]", idx), mem[idx], expected_word(idx));
		check_eq("write bursts", 64'(aw_count), 64'(`FMB_TEST_BURSTS));
		check_eq("read bursts", 64'(ar_count), 64'(`FMB_TEST_BURSTS));
	endtask

	// ------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------
	task automatic test_bring_up();
		int cycles;
		cycles = 0;
		hold_locks_low(1'b0, 1'b0, 1'b0);
		@(negedge iSCLK);
		check_eq("o_led", 64'(o_led), 64'd0);
		check_eq("o_ddr_axi_rstn", 64'(o_ddr_axi_rstn), 64'd0);
		check_eq("o_ddr_cfg_start", 64'(o_ddr_cfg_start), 64'd0);
		check_eq("o_ddr_cfg_reset", 64'(o_ddr_cfg_reset), 64'd1);
		@(posedge iSCLK);
		release_locks(1'b0);
		// Config reset held until start shows
		while ((o_ddr_cfg_start !== 1'b1) && (cycles < 4 * START_CYCLES))
		begin
			@(posedge iSCLK);
			@(negedge iSCLK);
			cycles++;
			if (o_ddr_cfg_start !== 1'b1)
				check_eq("o_ddr_cfg_reset", 64'(o_ddr_cfg_reset), 64'd1);
		end
		check_eq("cycles to o_ddr_cfg_start", 64'(cycles), 64'(START_CYCLES));
		// Calibration never reports done here
		repeat (10)
		begin
			@(negedge iSCLK);
			check_eq("o_ddr_cfg_start", 64'(o_ddr_cfg_start), 64'd1);
			check_eq("o_ddr_axi_rstn", 64'(o_ddr_axi_rstn), 64'd0);
		end
		@(posedge iSCLK);
		i_ddr_cfg_done <= 1'b1;
		@(negedge iSCLK);
		check_eq("o_ddr_axi_rstn", 64'(o_ddr_axi_rstn), 64'd0);
		@(negedge iSCLK);
		check_eq("o_ddr_axi_rstn", 64'(o_ddr_axi_rstn), 64'd1);
		check_eq("o_led[1]", 64'(o_led[1]), 64'd1);
	endtask

	task automatic test_clean_pass();
		run_memory_test(1'b0, 1'b0, 1'b0);
		check_clean_result();
	endtask

	task automatic test_back_pressure();
		run_memory_test(1'b1, 1'b0, 1'b0);
		check_clean_result();
	endtask

	task automatic test_read_corruption();
		run_memory_test(1'b0, 1'b1, 1'b0);
		check_eq("o_led", 64'(o_led), 64'(LED_FAIL));
		// First read burst fails and nothing is issued after it
		check_eq("read bursts", 64'(ar_count), 64'd1);
	endtask

	task automatic test_write_error();
		run_memory_test(1'b0, 1'b0, 1'b1);
		check_eq("o_led", 64'(o_led), 64'(LED_FAIL));
		check_eq("write bursts", 64'(aw_count), 64'd1);
		check_eq("read bursts", 64'(ar_count), 64'd0);
	endtask

	initial
	begin
		i_pb_sw          = 1'b0;
		i_pll_bl1_locked = 1'b0;
		i_pll_tl2_locked = 1'b0;
		i_ddr_cfg_done   = 1'b0;
		stall_en         = 1'b0;
		corrupt_en       = 1'b0;
		slverr_en        = 1'b0;
		test_bring_up();
		test_clean_pass();
		test_back_pressure();
		test_read_corruption();
		test_write_error();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/fmb_pkg.sv
design/mem_cmd_if.sv
design/ddr_reset_sequencer.sv
design/mem_test_ctrl.sv
design/axi_burst_writer.sv
design/axi_burst_reader.sv
design/fmb_tester_top.sv
dv/tb_fmb_tester.sv

/* run.sh */
#!/bin/sh
# Build the memory tester testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fmb_tester \
	-f filelist.f -Mdir obj_dir -o tb_fmb_tester
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_fmb_tester > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	echo "Result: passed"
	exit 0
fi
echo "Result: failed"
exit 1
